// ==== common/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int word_width = 8;  // Data bus and register width
    localparam int addr_width = 16; // H high byte, L low byte

    // Instruction opcodes
    typedef enum logic [7:0] {
        op_nop    = 8'h00,
        op_halt   = 8'h01,
        op_ldai   = 8'h02, // A from next byte
        op_ldbi   = 8'h03, // B from next byte
        op_lda_hl = 8'h04, // A from mem[HL]
        op_sta_hl = 8'h05, // A to mem[HL]
        op_add    = 8'h10,
        op_sub    = 8'h11,
        op_and    = 8'h12,
        op_or     = 8'h13,
        op_xor    = 8'h14,
        op_jmp    = 8'h20, // Followed by high, low address bytes
        op_jz     = 8'h21,
        op_mov_ab = 8'h30, // Source first, destination second
        op_mov_ba = 8'h31,
        op_mov_ah = 8'h32,
        op_mov_al = 8'h33
    } opcode_e;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_and,
        alu_or,
        alu_xor
    } alu_op_e;

    // Who drives the internal bus
    typedef enum logic [2:0] {
        bus_none,
        bus_a,
        bus_b,
        bus_h,
        bus_l,
        bus_alu,
        bus_mem
    } bus_src_e;

    typedef enum logic {
        addr_pc, // Instruction stream
        addr_m   // Data access through M
    } addr_sel_e;

endpackage

`default_nettype wire

// ==== control/controller.sv ====
`timescale 1ns/100ps
`default_nettype none

module controller (
    input  logic                            clk,
    input  logic                            ireg_reset,
    input  logic                            run,
    input  logic                            zero_flag,
    input  logic [cpu_pkg::word_width-1:0]  bus,
    output cpu_pkg::bus_src_e               bus_src,
    output logic                            a_load,
    output logic                            b_load,
    output logic                            h_load,
    output logic                            l_load,
    output logic                            mh_load,
    output logic                            ml_load,
    output logic                            flag_load,
    output cpu_pkg::alu_op_e                alu_op,
    output cpu_pkg::addr_sel_e              addr_sel,
    output logic                            mem_we,
    output logic                            pc_inc,
    output logic                            pc_load,
    output logic                            halted,
    output logic [3:0]                      stage_no
);

    cpu_pkg::opcode_e ir;     // Instruction register
    logic [3:0]       stage;
    logic             active;
    logic             fetch_step; // Last stage of every instruction
    logic             halt_set;

    assign active   = run && !halted;
    assign stage_no = stage;

    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            ir     <= cpu_pkg::op_nop;
            stage  <= 4'd0;
            halted <= 1'b0;
        end else begin
            if (fetch_step) begin
                ir <= cpu_pkg::opcode_e'(bus);
            end
            if (active) begin
                stage <= fetch_step ? 4'd0 : stage + 4'd1;
            end
            if (halt_set) begin
                halted <= 1'b1; // Sticky until reset
            end
        end
    end

    always_comb begin
        case (ir)
            cpu_pkg::op_sub: alu_op = cpu_pkg::alu_sub;
            cpu_pkg::op_and: alu_op = cpu_pkg::alu_and;
            cpu_pkg::op_or:  alu_op = cpu_pkg::alu_or;
            cpu_pkg::op_xor: alu_op = cpu_pkg::alu_xor;
            default:         alu_op = cpu_pkg::alu_add;
        endcase
    end

    always_comb begin
        bus_src    = cpu_pkg::bus_none;
        addr_sel   = cpu_pkg::addr_pc;
        a_load     = 1'b0;
        b_load     = 1'b0;
        h_load     = 1'b0;
        l_load     = 1'b0;
        mh_load    = 1'b0;
        ml_load    = 1'b0;
        flag_load  = 1'b0;
        mem_we     = 1'b0;
        pc_inc     = 1'b0;
        pc_load    = 1'b0;
        fetch_step = 1'b0;
        halt_set   = 1'b0;

        if (active) begin
            case (ir)
                cpu_pkg::op_halt: begin
                    halt_set = 1'b1;
                end
                cpu_pkg::op_ldai, cpu_pkg::op_ldbi: begin
                    if (stage == 4'd0) begin // Immediate byte at pc
                        bus_src = cpu_pkg::bus_mem;
                        a_load  = (ir == cpu_pkg::op_ldai);
                        b_load  = (ir == cpu_pkg::op_ldbi);
                        pc_inc  = 1'b1;
                    end else begin
                        fetch_step = 1'b1;
                    end
                end
                cpu_pkg::op_lda_hl, cpu_pkg::op_sta_hl: begin
                    case (stage)
                        4'd0: begin
                            bus_src = cpu_pkg::bus_h;
                            mh_load = 1'b1;
                        end
                        4'd1: begin
                            bus_src = cpu_pkg::bus_l;
                            ml_load = 1'b1;
                        end
                        4'd2: begin
                            addr_sel = cpu_pkg::addr_m;
                            if (ir == cpu_pkg::op_lda_hl) begin
                                bus_src = cpu_pkg::bus_mem;
                                a_load  = 1'b1;
                            end else begin
                                bus_src = cpu_pkg::bus_a;
                                mem_we  = 1'b1;
                            end
                        end
                        default: fetch_step = 1'b1;
                    endcase
                end
                cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
                cpu_pkg::op_or, cpu_pkg::op_xor: begin
                    if (stage == 4'd0) begin // Result and flag in one cycle
                        bus_src   = cpu_pkg::bus_alu;
                        a_load    = 1'b1;
                        flag_load = 1'b1;
                    end else begin
                        fetch_step = 1'b1;
                    end
                end
                cpu_pkg::op_jmp, cpu_pkg::op_jz: begin
                    if (ir == cpu_pkg::op_jz && !zero_flag) begin
                        // Not taken, step over both address bytes
                        if (stage < 4'd2) begin
                            pc_inc = 1'b1;
                        end else begin
                            fetch_step = 1'b1;
                        end
                    end else begin
                        case (stage)
                            4'd0: begin
                                bus_src = cpu_pkg::bus_mem;
                                mh_load = 1'b1;
                                pc_inc  = 1'b1;
                            end
                            4'd1: begin
                                bus_src = cpu_pkg::bus_mem;
                                ml_load = 1'b1;
                                pc_inc  = 1'b1;
                            end
                            4'd2: pc_load = 1'b1; // Target from M
                            default: fetch_step = 1'b1;
                        endcase
                    end
                end
                cpu_pkg::op_mov_ab, cpu_pkg::op_mov_ba,
                cpu_pkg::op_mov_ah, cpu_pkg::op_mov_al: begin
                    if (stage == 4'd0) begin
                        bus_src = (ir == cpu_pkg::op_mov_ba) ? cpu_pkg::bus_b : cpu_pkg::bus_a;
                        a_load  = (ir == cpu_pkg::op_mov_ba);
                        b_load  = (ir == cpu_pkg::op_mov_ab);
                        h_load  = (ir == cpu_pkg::op_mov_ah);
                        l_load  = (ir == cpu_pkg::op_mov_al);
                    end else begin
                        fetch_step = 1'b1;
                    end
                end
                default: fetch_step = 1'b1; // NOP and unknown opcodes
            endcase

            if (fetch_step) begin // Next opcode from mem[pc]
                bus_src  = cpu_pkg::bus_mem;
                addr_sel = cpu_pkg::addr_pc;
                pc_inc   = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

// ==== datapath/reg_bank.sv ====
`timescale 1ns/100ps
`default_nettype none

module reg_bank (
    input  logic                            clk,
    input  logic                            ireg_reset,
    input  logic                            a_load,
    input  logic                            b_load,
    input  logic                            h_load,
    input  logic                            l_load,
    input  logic                            mh_load,
    input  logic                            ml_load,
    input  logic                            flag_load,
    input  cpu_pkg::bus_src_e               bus_src,
    input  logic [cpu_pkg::word_width-1:0]  alu_result,
    input  logic [cpu_pkg::word_width-1:0]  mem_rdata,
    input  logic                            alu_zero,
    output logic [cpu_pkg::word_width-1:0]  bus,
    output logic [cpu_pkg::word_width-1:0]  a_value,
    output logic [cpu_pkg::word_width-1:0]  b_value,
    output logic [cpu_pkg::addr_width-1:0]  m_addr,
    output logic                            zero_flag
);

    logic [cpu_pkg::word_width-1:0] a_reg;
    logic [cpu_pkg::word_width-1:0] b_reg;
    logic [cpu_pkg::word_width-1:0] h_reg;
    logic [cpu_pkg::word_width-1:0] l_reg;
    logic [cpu_pkg::word_width-1:0] mh_reg; // Memory address high byte
    logic [cpu_pkg::word_width-1:0] ml_reg; // Memory address low byte

    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            a_reg     <= '0;
            b_reg     <= '0;
            h_reg     <= '0;
            l_reg     <= '0;
            mh_reg    <= '0;
            ml_reg    <= '0;
            zero_flag <= 1'b0;
        end else begin
            if (a_load) begin
                a_reg <= bus;
            end
            if (b_load) begin
                b_reg <= bus;
            end
            if (h_load) begin
                h_reg <= bus;
            end
            if (l_load) begin
                l_reg <= bus;
            end
            if (mh_load) begin
                mh_reg <= bus;
            end
            if (ml_load) begin
                ml_reg <= bus;
            end
            if (flag_load) begin
                zero_flag <= alu_zero;
            end
        end
    end

    // Single internal bus, one source at a time
    always_comb begin
        case (bus_src)
            cpu_pkg::bus_a:   bus = a_reg;
            cpu_pkg::bus_b:   bus = b_reg;
            cpu_pkg::bus_h:   bus = h_reg;
            cpu_pkg::bus_l:   bus = l_reg;
            cpu_pkg::bus_alu: bus = alu_result;
            cpu_pkg::bus_mem: bus = mem_rdata;
            default:          bus = '0; // Idle bus
        endcase
    end

    assign a_value = a_reg;
    assign b_value = b_reg;
    assign m_addr  = {mh_reg, ml_reg};

endmodule

`default_nettype wire

// ==== datapath/alu.sv ====
`timescale 1ns/100ps
`default_nettype none

module alu (
    input  logic [cpu_pkg::word_width-1:0]  a_value,
    input  logic [cpu_pkg::word_width-1:0]  b_value,
    input  cpu_pkg::alu_op_e                alu_op,
    output logic [cpu_pkg::word_width-1:0]  alu_result,
    output logic                            alu_zero
);

    always_comb begin
        case (alu_op)
            cpu_pkg::alu_sub: alu_result = a_value - b_value; // Wraps modulo 256
            cpu_pkg::alu_and: alu_result = a_value & b_value;
            cpu_pkg::alu_or:  alu_result = a_value | b_value;
            cpu_pkg::alu_xor: alu_result = a_value ^ b_value;
            default:          alu_result = a_value + b_value; // Carry dropped
        endcase
    end

    assign alu_zero = (alu_result == '0);

endmodule

`default_nettype wire

// ==== logic/program_counter.sv ====
`timescale 1ns/100ps
`default_nettype none

module program_counter (
    input  logic                            clk,
    input  logic                            ireg_reset,
    input  logic                            pc_inc,
    input  logic                            pc_load,
    input  logic [cpu_pkg::addr_width-1:0]  m_addr,
    output logic [cpu_pkg::addr_width-1:0]  pc
);

    always_ff @(posedge clk) begin
        if (ireg_reset) begin
            pc <= '0; // Execution starts at address 0
        end else if (pc_load) begin
            pc <= m_addr; // Jump wins over increment
        end else if (pc_inc) begin
            pc <= pc + 1'b1;
        end
    end

endmodule

`default_nettype wire

// ==== logic/memory.sv ====
`timescale 1ns/100ps
`default_nettype none

module memory #(
    parameter int mem_addr_width = 8
) (
    input  logic                            clk,
    input  logic                            mem_we,
    input  logic                            prog_we,
    input  cpu_pkg::addr_sel_e              addr_sel,
    input  logic [cpu_pkg::addr_width-1:0]  pc,
    input  logic [cpu_pkg::addr_width-1:0]  m_addr,
    input  logic [cpu_pkg::addr_width-1:0]  prog_addr,
    input  logic [cpu_pkg::word_width-1:0]  bus,
    input  logic [cpu_pkg::word_width-1:0]  prog_wdata,
    output logic [cpu_pkg::word_width-1:0]  mem_rdata,
    output logic [cpu_pkg::word_width-1:0]  prog_rdata
);

    localparam int depth = 2 ** mem_addr_width;

    logic [cpu_pkg::word_width-1:0] mem_array [depth];
    logic [cpu_pkg::addr_width-1:0] core_addr;
    logic [mem_addr_width-1:0]      core_idx;
    logic [mem_addr_width-1:0]      prog_idx;

    assign core_addr = (addr_sel == cpu_pkg::addr_m) ? m_addr : pc;
    assign core_idx  = core_addr[mem_addr_width-1:0]; // Upper bits alias
    assign prog_idx  = prog_addr[mem_addr_width-1:0];

    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem_array[prog_idx] <= prog_wdata;
        end
        if (mem_we) begin
            mem_array[core_idx] <= bus; // Core store wins on a clash
        end
    end

    // Both ports read asynchronously
    assign mem_rdata  = mem_array[core_idx];
    assign prog_rdata = mem_array[prog_idx];

endmodule

`default_nettype wire

// ==== logic/cpu_top.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_top #(
    parameter int mem_addr_width = 8
) (
    input  logic                            clk,
    input  logic                            ireg_reset,
    input  logic                            run,
    input  logic                            prog_we,
    input  logic [cpu_pkg::addr_width-1:0]  prog_addr,
    input  logic [cpu_pkg::word_width-1:0]  prog_wdata,
    output logic [cpu_pkg::word_width-1:0]  prog_rdata,
    output logic                            halted,
    output logic [3:0]                      stage_no
);

    logic [cpu_pkg::word_width-1:0] bus;
    logic [cpu_pkg::word_width-1:0] a_value;
    logic [cpu_pkg::word_width-1:0] b_value;
    logic [cpu_pkg::word_width-1:0] alu_result;
    logic [cpu_pkg::word_width-1:0] mem_rdata;
    logic [cpu_pkg::addr_width-1:0] m_addr;
    logic [cpu_pkg::addr_width-1:0] pc;
    cpu_pkg::bus_src_e              bus_src;
    cpu_pkg::alu_op_e               alu_op;
    cpu_pkg::addr_sel_e             addr_sel;
    logic                           a_load;
    logic                           b_load;
    logic                           h_load;
    logic                           l_load;
    logic                           mh_load;
    logic                           ml_load;
    logic                           flag_load;
    logic                           mem_we;
    logic                           pc_inc;
    logic                           pc_load;
    logic                           zero_flag;
    logic                           alu_zero;

    controller u_controller (
        .clk        (clk),
        .ireg_reset (ireg_reset),
        .run        (run),
        .zero_flag  (zero_flag),
        .bus        (bus),
        .bus_src    (bus_src),
        .a_load     (a_load),
        .b_load     (b_load),
        .h_load     (h_load),
        .l_load     (l_load),
        .mh_load    (mh_load),
        .ml_load    (ml_load),
        .flag_load  (flag_load),
        .alu_op     (alu_op),
        .addr_sel   (addr_sel),
        .mem_we     (mem_we),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .halted     (halted),
        .stage_no   (stage_no)
    );

    reg_bank u_reg_bank (
        .clk        (clk),
        .ireg_reset (ireg_reset),
        .a_load     (a_load),
        .b_load     (b_load),
        .h_load     (h_load),
        .l_load     (l_load),
        .mh_load    (mh_load),
        .ml_load    (ml_load),
        .flag_load  (flag_load),
        .bus_src    (bus_src),
        .alu_result (alu_result),
        .mem_rdata  (mem_rdata),
        .alu_zero   (alu_zero),
        .bus        (bus),
        .a_value    (a_value),
        .b_value    (b_value),
        .m_addr     (m_addr),
        .zero_flag  (zero_flag)
    );

    alu u_alu (
        .a_value    (a_value),
        .b_value    (b_value),
        .alu_op     (alu_op),
        .alu_result (alu_result),
        .alu_zero   (alu_zero)
    );

    program_counter u_program_counter (
        .clk        (clk),
        .ireg_reset (ireg_reset),
        .pc_inc     (pc_inc),
        .pc_load    (pc_load),
        .m_addr     (m_addr),
        .pc         (pc)
    );

    memory #(
        .mem_addr_width (mem_addr_width)
    ) u_memory (
        .clk        (clk),
        .mem_we     (mem_we),
        .prog_we    (prog_we),
        .addr_sel   (addr_sel),
        .pc         (pc),
        .m_addr     (m_addr),
        .prog_addr  (prog_addr),
        .bus        (bus),
        .prog_wdata (prog_wdata),
        .mem_rdata  (mem_rdata),
        .prog_rdata (prog_rdata)
    );

endmodule

`default_nettype wire

// ==== dv/cpu_tests.svh ====
    task automatic store_immediates();
        logic [7:0] imm_a;
        logic [7:0] imm_b;
        imm_a = rand_byte();
        imm_b = rand_byte();
        apply_reset();
        new_program();
        set_hl(16'h0090);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(imm_a);
        append_opcode(cpu_pkg::op_sta_hl);
        append_opcode(cpu_pkg::op_ldbi);
        append_byte(imm_b);
        set_hl(16'h0091);
        append_opcode(cpu_pkg::op_mov_ba); // B reaches memory through A
        append_opcode(cpu_pkg::op_sta_hl);
        append_opcode(cpu_pkg::op_halt);
        load_program();
        run_to_halt();
        expect_mem(16'h0090, imm_a);
        expect_mem(16'h0091, imm_b);
    endtask

    task automatic exercise_alu();
        cpu_pkg::opcode_e ops[5];
        logic [7:0]       x[5];
        logic [7:0]       y[5];
        logic [7:0]       expected;
        ops = '{cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
                cpu_pkg::op_or, cpu_pkg::op_xor};
        apply_reset();
        new_program();
        for (int i = 0; i < 5; i++) begin
            x[i] = rand_byte();
            y[i] = rand_byte();
            set_hl(16'h00a0 + 16'(i));
            append_opcode(cpu_pkg::op_ldai);
            append_byte(x[i]);
            append_opcode(cpu_pkg::op_ldbi);
            append_byte(y[i]);
            append_opcode(ops[i]);
            append_opcode(cpu_pkg::op_sta_hl);
        end
        append_opcode(cpu_pkg::op_halt);
        load_program();
        run_to_halt();
        for (int i = 0; i < 5; i++) begin
            case (ops[i])
                cpu_pkg::op_add: expected = x[i] + y[i]; // 8-bit wrap
                cpu_pkg::op_sub: expected = x[i] - y[i];
                cpu_pkg::op_and: expected = x[i] & y[i];
                cpu_pkg::op_or:  expected = x[i] | y[i];
                default:         expected = x[i] ^ y[i];
            endcase
            expect_mem(16'h00a0 + 16'(i), expected);
        end
    endtask

    task automatic read_back_memory();
        logic [7:0] value;
        logic [7:0] doubled;
        value   = rand_byte();
        doubled = value + value;
        apply_reset();
        new_program();
        preload_byte(16'h00b0, value);
        set_hl(16'h00b0);
        append_opcode(cpu_pkg::op_lda_hl);
        append_opcode(cpu_pkg::op_mov_ab);
        append_opcode(cpu_pkg::op_add);
        append_opcode(cpu_pkg::op_sta_hl); // Sum overwrites the source byte
        append_opcode(cpu_pkg::op_halt);
        load_program();
        run_to_halt();
        expect_mem(16'h00b0, doubled);
    endtask

    task automatic take_jumps();
        logic [7:0]  keep;
        logic [7:0]  same;
        logic [7:0]  first;
        logic [7:0]  delta;
        logic [15:0] target;
        keep  = rand_byte();
        same  = rand_byte();
        first = rand_byte();
        delta = rand_byte();
        if (keep == 8'h5a) begin
            keep = 8'ha5;
        end
        if (delta == 8'h00) begin
            delta = 8'h01; // Keeps the second SUB nonzero
        end
        apply_reset();
        new_program();
        preload_byte(16'h00c0, keep);
        preload_byte(16'h00c1, 8'h00);
        preload_byte(16'h00c2, 8'h00);
        set_hl(16'h00c0);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(8'h5a);
        append_opcode(cpu_pkg::op_jmp);
        target = 16'(prog.size() + 3);
        append_byte(target[15:8]);
        append_byte(target[7:0]);
        on_path = 1'b0;
        append_opcode(cpu_pkg::op_sta_hl); // Jumped over
        on_path = 1'b1;
        set_hl(16'h00c1);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(same);
        append_opcode(cpu_pkg::op_ldbi);
        append_byte(same);
        append_opcode(cpu_pkg::op_sub);
        append_jz(1'b1);
        target = 16'(prog.size() + 6);
        append_byte(target[15:8]);
        append_byte(target[7:0]);
        on_path = 1'b0;
        append_opcode(cpu_pkg::op_ldai); // Wrong path marks c1 and stops
        append_byte(8'hbd);
        append_opcode(cpu_pkg::op_sta_hl);
        append_opcode(cpu_pkg::op_halt);
        on_path = 1'b1;
        append_opcode(cpu_pkg::op_ldai);
        append_byte(8'h11);
        append_opcode(cpu_pkg::op_sta_hl);
        set_hl(16'h00c2);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(first);
        append_opcode(cpu_pkg::op_ldbi);
        append_byte(first + delta);
        append_opcode(cpu_pkg::op_sub);
        append_jz(1'b0);
        target = 16'(prog.size() + 6);
        append_byte(target[15:8]);
        append_byte(target[7:0]);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(8'h22);
        append_opcode(cpu_pkg::op_sta_hl);
        append_opcode(cpu_pkg::op_halt);
        on_path = 1'b0;
        append_opcode(cpu_pkg::op_ldai); // Branch target, must not run
        append_byte(8'hbd);
        append_opcode(cpu_pkg::op_sta_hl);
        append_opcode(cpu_pkg::op_halt);
        load_program();
        run_to_halt();
        expect_mem(16'h00c0, keep);
        expect_mem(16'h00c1, 8'h11);
        expect_mem(16'h00c2, 8'h22);
    endtask

    task automatic time_halt();
        logic [7:0] keep;
        keep = rand_byte();
        apply_reset();
        new_program();
        preload_byte(16'h00d0, keep);
        set_hl(16'h00d0);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(~keep);
        append_opcode(cpu_pkg::op_nop);
        append_opcode(cpu_pkg::opcode_e'(8'h7f)); // Unknown opcode runs as NOP
        append_opcode(cpu_pkg::op_mov_ab);
        append_opcode(cpu_pkg::op_halt);
        on_path = 1'b0;
        append_opcode(cpu_pkg::op_sta_hl);
        load_program();
        run_to_halt();
        cycle_budget += 20;
        repeat (20) begin
            @(posedge clk);
            @(negedge clk);
            check_value("halted", halted, 1'b1);
        end
        expect_mem(16'h00d0, keep);
    endtask

// ==== dv/cpu_tb.sv ====
`timescale 1ns/100ps
`default_nettype none

module cpu_tb;

    logic        clk;
    logic        ireg_reset;
    logic        run;
    logic        prog_we;
    logic [15:0] prog_addr;
    logic [7:0]  prog_wdata;
    logic [7:0]  prog_rdata;
    logic        halted;
    logic [3:0]  stage_no;

    int          seed = 83;
    int          cycle_count = 0;
    int          cycle_budget = 100; // Grows as each test reserves its cycles
    int          run_cycles;         // Table cycles of the path that executes
    bit          on_path;            // Code being appended will execute
    logic [7:0]  prog[$];
    logic [15:0] pre_addr[$];
    logic [7:0]  pre_data[$];

    cpu_top #(
        .mem_addr_width (8)
    ) DUT (
        .clk        (clk),
        .ireg_reset (ireg_reset),
        .run        (run),
        .prog_we    (prog_we),
        .prog_addr  (prog_addr),
        .prog_wdata (prog_wdata),
        .prog_rdata (prog_rdata),
        .halted     (halted),
        .stage_no   (stage_no)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle_count++;
        if (cycle_count > cycle_budget) begin
            $display("Timeout: the run needed more than %0d clock cycles", cycle_budget);
            $display("Simulation failed");
            $fatal(1, "timeout");
        end
    end

    task automatic check_value(input string name, input logic [15:0] actual,
                               input logic [15:0] expected);
        if (actual !== expected) begin
            $display("FAILED at %0t ns: %s = 0x%0h, expected 0x%0h",
                     $time, name, actual, expected);
            $display("Simulation failed");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [7:0] rand_byte();
        logic [31:0] r;
        r = $random(seed);
        return r[7:0];
    endfunction

    // Cycles per instruction, fetch of the next opcode included
    function automatic int cycles_of(input cpu_pkg::opcode_e op);
        case (op)
            cpu_pkg::op_ldai, cpu_pkg::op_ldbi,
            cpu_pkg::op_add, cpu_pkg::op_sub, cpu_pkg::op_and,
            cpu_pkg::op_or, cpu_pkg::op_xor,
            cpu_pkg::op_mov_ab, cpu_pkg::op_mov_ba,
            cpu_pkg::op_mov_ah, cpu_pkg::op_mov_al: return 2;
            cpu_pkg::op_lda_hl, cpu_pkg::op_sta_hl,
            cpu_pkg::op_jmp, cpu_pkg::op_jz: return 4; // JZ counted as taken
            default: return 1;
        endcase
    endfunction

    task automatic new_program();
        prog.delete();
        pre_addr.delete();
        pre_data.delete();
        run_cycles = 0;
        on_path    = 1'b1;
    endtask

    task automatic append_opcode(input cpu_pkg::opcode_e op);
        prog.push_back(op);
        if (on_path) begin
            run_cycles += cycles_of(op);
        end
    endtask

    task automatic append_jz(input bit taken);
        prog.push_back(cpu_pkg::op_jz);
        if (on_path) begin
            run_cycles += taken ? 4 : 3;
        end
    endtask

    task automatic append_byte(input logic [7:0] value);
        prog.push_back(value);
    endtask

    // HL via A, so A is lost
    task automatic set_hl(input logic [15:0] addr);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(addr[15:8]);
        append_opcode(cpu_pkg::op_mov_ah);
        append_opcode(cpu_pkg::op_ldai);
        append_byte(addr[7:0]);
        append_opcode(cpu_pkg::op_mov_al);
    endtask

    task automatic preload_byte(input logic [15:0] addr, input logic [7:0] value);
        pre_addr.push_back(addr);
        pre_data.push_back(value);
    endtask

    task automatic apply_reset();
        cycle_budget += 5;
        @(posedge clk);
        ireg_reset <= 1'b1;
        run        <= 1'b0;
        prog_we    <= 1'b0;
        repeat (4) @(posedge clk);
        ireg_reset <= 1'b0;
        @(negedge clk);
        check_value("halted", halted, 1'b0);
        check_value("stage_no", stage_no, 4'd0);
    endtask

    task automatic load_program();
        cycle_budget += prog.size() + pre_addr.size() + 1;
        foreach (prog[i]) begin
            @(posedge clk);
            prog_we    <= 1'b1;
            prog_addr  <= 16'(i);
            prog_wdata <= prog[i];
        end
        foreach (pre_addr[i]) begin // Data bytes go above the code
            @(posedge clk);
            prog_we    <= 1'b1;
            prog_addr  <= pre_addr[i];
            prog_wdata <= pre_data[i];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic run_to_halt();
        int count;
        count = 0;
        cycle_budget += run_cycles + 2;
        @(posedge clk);
        run <= 1'b1;
        while (!halted) begin
            @(posedge clk);
            count++;
            @(negedge clk); // halted is stable here
        end
        check_value("cycles to halted", 16'(count), 16'(run_cycles + 1));
    endtask

    task automatic expect_mem(input logic [15:0] addr, input logic [7:0] expected);
        cycle_budget += 1;
        @(posedge clk);
        prog_addr <= addr;
        @(negedge clk);
        check_value($sformatf("mem[0x%02h]", addr), prog_rdata, expected);
    endtask

`include "cpu_tests.svh"

    initial begin
        ireg_reset = 1'b1;
        run        = 1'b0;
        prog_we    = 1'b0;
        prog_addr  = '0;
        prog_wdata = '0;
        store_immediates();
        exercise_alu();
        read_back_memory();
        take_jumps();
        time_halt();
        $display("Simulation passed");
        $finish;
    end

endmodule

`default_nettype wire

// ==== compile.f ====
+incdir+dv
common/cpu_pkg.sv
control/controller.sv
datapath/reg_bank.sv
datapath/alu.sv
logic/program_counter.sv
logic/memory.sv
logic/cpu_top.sv
dv/cpu_tb.sv

// ==== Bender.yml ====
package:
  name: cpu

sources:
  - files:
      - common/cpu_pkg.sv
      - control/controller.sv
      - datapath/reg_bank.sv
      - datapath/alu.sv
      - logic/program_counter.sv
      - logic/memory.sv
      - logic/cpu_top.sv
  - target: test
    include_dirs:
      - dv
    files:
      - dv/cpu_tb.sv
